// File: source/dcache_pkg.sv
package dcache_pkg;

    // geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_SETS       = 256;
    localparam int OFFSET_WIDTH   = 4;   // byte offset in a line
    localparam int INDEX_WIDTH    = 8;
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int NUM_WAYS       = 2;

    typedef logic [ADDR_WIDTH-1:0]                addr_t;
    typedef logic [WORD_WIDTH-1:0]                word_t;
    typedef logic [WORD_WIDTH/8-1:0]              strb_t;
    typedef logic [WORDS_PER_LINE*WORD_WIDTH-1:0] line_t;  // word 0 in low bits
    typedef logic [TAG_WIDTH-1:0]                 tag_t;
    typedef logic [INDEX_WIDTH-1:0]               index_t;
    typedef logic [OFFSET_WIDTH-1:0]              offset_t;
    typedef logic [NUM_WAYS-1:0]                  way_mask_t;

    // miss handling sequence of the controller
    typedef enum logic [2:0] {
        LOOKUP      = 3'd0,
        MISS_DIRTY  = 3'd1,   // waiting for write channel
        WRITEBACK   = 3'd2,
        MISS_CLEAN  = 3'd3,   // waiting for read channel
        REFILL      = 3'd4,
        REFILL_DONE = 3'd5    // re-read of the set
    } miss_state_t;

endpackage

// File: source/dcache_array_if.sv
`timescale 1ns/1ps

interface dcache_array_if import dcache_pkg::*; ();

    // lookup
    logic                                    rd_en;
    index_t                                  rd_index;

    // tag/valid write, valid is set on every tag write
    way_mask_t                               tag_we;
    index_t                                  tag_index;
    tag_t                                    tag_wdata;

    way_mask_t                               dirty_we;
    index_t                                  dirty_index;
    logic                                    dirty_wbit;

    logic [NUM_WAYS-1:0][WORDS_PER_LINE-1:0] data_we;     // per way, per word
    index_t                                  data_index;
    line_t                                   data_wline;

    // registered read results
    tag_t  [NUM_WAYS-1:0]                    tag_q;
    way_mask_t                               valid_q;
    way_mask_t                               dirty_q;
    line_t [NUM_WAYS-1:0]                    line_q;

    modport ctrl (
        output rd_en, rd_index, tag_we, tag_index, tag_wdata,
        output dirty_we, dirty_index, dirty_wbit, data_we, data_index, data_wline,
        input  tag_q, valid_q, dirty_q, line_q
    );

    modport arrays (
        input  rd_en, rd_index, tag_we, tag_index, tag_wdata,
        input  dirty_we, dirty_index, dirty_wbit, data_we, data_index, data_wline,
        output tag_q, valid_q, dirty_q, line_q
    );

endinterface

// File: source/dcache_arrays.sv
`timescale 1ns/1ps

module dcache_arrays import dcache_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    dcache_array_if.arrays arr
);

    tag_t                tag_mem   [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_mem [NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_mem [NUM_WAYS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (arr.tag_we[w])
                tag_mem[w][arr.tag_index] <= arr.tag_wdata;
            if (arr.rd_en)
                arr.tag_q[w] <= tag_mem[w][arr.rd_index];  // old value on same-cycle write
        end
    end

    // valid and dirty bits, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_mem[w] <= '0;
                dirty_mem[w] <= '0;
            end
            arr.valid_q <= '0;
            arr.dirty_q <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (arr.tag_we[w])
                    valid_mem[w][arr.tag_index] <= 1'b1;
                if (arr.dirty_we[w])
                    dirty_mem[w][arr.dirty_index] <= arr.dirty_wbit;
                if (arr.rd_en) begin
                    arr.valid_q[w] <= valid_mem[w][arr.rd_index];
                    arr.dirty_q[w] <= dirty_mem[w][arr.rd_index];
                end
            end
        end
    end

    // one word-wide memory per way and word
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        for (genvar k = 0; k < WORDS_PER_LINE; k++) begin : g_word
            word_t word_mem [NUM_SETS];
            word_t word_q;

            always_ff @(posedge clk) begin
                if (arr.data_we[w][k])
                    word_mem[arr.data_index] <= arr.data_wline[k*WORD_WIDTH +: WORD_WIDTH];
                if (arr.rd_en)
                    word_q <= word_mem[arr.rd_index];
            end

            assign arr.line_q[w][k*WORD_WIDTH +: WORD_WIDTH] = word_q;
        end
    end

    // refill goes to the victim only, a store to the hit way only
    a_data_we_one_way: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({|arr.data_we[1], |arr.data_we[0]})
    ) else $error("data_we enables both ways");

endmodule

// File: source/dcache_plru.sv
`timescale 1ns/1ps

module dcache_plru import dcache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  index_t    index,
    input  logic      update,
    input  way_mask_t hit_way,
    output logic      victim
);

    logic [NUM_SETS-1:0] evict_bit;  // way to evict next, per set

    always_ff @(posedge clk) begin
        if (reset)
            evict_bit <= '0;
        else if (update)
            evict_bit[index] <= hit_way[0];  // way 0 used, so way 1 goes next
    end

    assign victim = evict_bit[index];

    a_hit_way_not_two_hot: assert property (
        @(posedge clk) disable iff (reset)
        update |-> !(&hit_way)
    ) else $error("plru update with both ways hit");

endmodule

// File: source/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         data_valid,
    input  logic         data_op,
    input  addr_t        data_addr,
    input  word_t        data_wdata,
    input  strb_t        data_strb,
    output word_t        data_rdata,
    output logic         busy,
    output logic         mem_rd_req,
    output addr_t        mem_rd_addr,
    input  logic         mem_rd_rdy,
    input  logic         mem_ret_valid,
    input  line_t        mem_ret_data,
    output logic         mem_wr_req,
    output addr_t        mem_wr_addr,
    output line_t        mem_wr_data,
    input  logic         mem_wr_rdy,
    input  logic         mem_wr_valid,
    dcache_array_if.ctrl arr,
    output index_t       plru_index,
    output logic         plru_update,
    output way_mask_t    plru_hit_way,
    input  logic         victim
);

    miss_state_t state;
    miss_state_t state_next;

    // request buffer
    logic    req_valid;
    logic    req_op;
    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    word_t   req_wdata;
    strb_t   req_strb;

    // write buffer
    logic                    wr_pending;
    way_mask_t               wb_way;
    index_t                  wb_index;
    logic [OFFSET_WIDTH-3:0] wb_wsel;
    word_t                   wb_word;

    // store written in the same cycle as a read of its set
    logic [NUM_WAYS-1:0][WORDS_PER_LINE-1:0] fwd_we;
    way_mask_t                               fwd_dirty;
    word_t                                   fwd_word;

    logic [NUM_WAYS-1:0][WORDS_PER_LINE-1:0] data_we;
    line_t [NUM_WAYS-1:0]                    eff_line;
    word_t [NUM_WAYS-1:0]                    eff_word;
    way_mask_t                               eff_dirty;
    way_mask_t                               hit_way;
    way_mask_t                               victim_mask;
    logic [OFFSET_WIDTH-3:0]                 req_wsel;
    logic                                    lookup;
    logic                                    hit;
    logic                                    accept;
    logic                                    refill_wr;
    word_t                                   hit_word;
    word_t                                   merged;

    assign accept      = data_valid & ~busy;
    assign lookup      = req_valid & (state == LOOKUP);
    assign req_wsel    = req_offset[OFFSET_WIDTH-1:2];
    assign victim_mask = victim ? 2'b10 : 2'b01;
    assign refill_wr   = (state == REFILL) & mem_ret_valid;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                eff_line[w][k*WORD_WIDTH +: WORD_WIDTH] =
                    fwd_we[w][k] ? fwd_word : arr.line_q[w][k*WORD_WIDTH +: WORD_WIDTH];
            end
            eff_word[w] = eff_line[w][req_wsel*WORD_WIDTH +: WORD_WIDTH];
            hit_way[w]  = arr.valid_q[w] & (arr.tag_q[w] == req_tag);
        end
    end

    assign eff_dirty  = arr.dirty_q | fwd_dirty;
    assign hit        = |hit_way;
    assign hit_word   = hit_way[1] ? eff_word[1] : eff_word[0];
    assign data_rdata = hit_word;

    // stores stall one cycle for the merge
    assign busy = (state != LOOKUP) | (req_valid & (~hit | req_op));

    always_comb begin
        for (int b = 0; b < WORD_WIDTH/8; b++)
            merged[b*8 +: 8] = req_strb[b] ? req_wdata[b*8 +: 8] : hit_word[b*8 +: 8];
    end

    always_ff @(posedge clk) begin
        if (reset)
            req_valid <= 1'b0;
        else if (accept)
            req_valid <= 1'b1;
        else if (lookup && hit)
            req_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op     <= data_op;
            req_tag    <= data_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
            req_index  <= data_addr[OFFSET_WIDTH +: INDEX_WIDTH];
            req_offset <= data_addr[OFFSET_WIDTH-1:0];
            req_wdata  <= data_wdata;
            req_strb   <= data_strb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            wr_pending <= 1'b0;
        else
            wr_pending <= lookup & hit & req_op;
    end

    always_ff @(posedge clk) begin
        if (lookup && hit && req_op) begin
            wb_way   <= hit_way;
            wb_index <= req_index;
            wb_wsel  <= req_wsel;
            wb_word  <= merged;
        end
    end

    // captured with each read, lives as long as the read result
    always_ff @(posedge clk) begin
        if (reset) begin
            fwd_we    <= '0;
            fwd_dirty <= '0;
        end else if (arr.rd_en) begin
            if (wr_pending && (arr.rd_index == wb_index)) begin
                fwd_we    <= data_we;
                fwd_dirty <= wb_way;
            end else begin
                fwd_we    <= '0;
                fwd_dirty <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.rd_en)
            fwd_word <= wb_word;
    end

    always_comb begin
        data_we = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (wr_pending)
                data_we[w][wb_wsel] = wb_way[w];
            else if (refill_wr && victim_mask[w])
                data_we[w] = '1;
        end
    end

    assign arr.rd_en       = accept | (state == REFILL_DONE);
    assign arr.rd_index    = (state == REFILL_DONE) ? req_index
                                                    : data_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign arr.tag_we      = refill_wr ? victim_mask : '0;
    assign arr.tag_index   = req_index;
    assign arr.tag_wdata   = req_tag;
    assign arr.dirty_we    = wr_pending ? wb_way : (refill_wr ? victim_mask : '0);
    assign arr.dirty_index = wr_pending ? wb_index : req_index;
    assign arr.dirty_wbit  = wr_pending;  // refill clears it
    assign arr.data_we     = data_we;
    assign arr.data_index  = wr_pending ? wb_index : req_index;
    assign arr.data_wline  = wr_pending ? {WORDS_PER_LINE{wb_word}} : mem_ret_data;

    assign plru_index   = req_index;
    assign plru_update  = lookup & hit;
    assign plru_hit_way = hit_way;

    always_ff @(posedge clk) begin
        if (reset)
            state <= LOOKUP;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP:
                if (lookup && !hit)
                    state_next = eff_dirty[victim] ? MISS_DIRTY : MISS_CLEAN;
            MISS_DIRTY:
                if (mem_wr_rdy)
                    state_next = WRITEBACK;
            WRITEBACK:
                if (mem_wr_valid)
                    state_next = MISS_CLEAN;
            MISS_CLEAN:
                if (mem_rd_rdy)
                    state_next = REFILL;
            REFILL:
                if (mem_ret_valid)
                    state_next = REFILL_DONE;
            REFILL_DONE:
                state_next = LOOKUP;
            default:
                state_next = LOOKUP;
        endcase
    end

    assign mem_wr_req  = (state == MISS_DIRTY);
    assign mem_wr_addr = {arr.tag_q[victim], req_index, {OFFSET_WIDTH{1'b0}}};
    assign mem_wr_data = eff_line[victim];
    assign mem_rd_req  = (state == MISS_CLEAN);
    assign mem_rd_addr = {req_tag, req_index, {OFFSET_WIDTH{1'b0}}};

    a_one_bus_req: assert property (
        @(posedge clk) disable iff (reset)
        !(mem_rd_req && mem_wr_req)
    ) else $error("read and write requests both high");

    a_busy_in_miss: assert property (
        @(posedge clk) disable iff (reset)
        (state != LOOKUP) |-> busy && req_valid
    ) else $error("miss handling while not busy or without a held request");

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    // cpu side
    input  logic  data_valid,
    input  logic  data_op,       // 1 is store
    input  addr_t data_addr,
    input  word_t data_wdata,
    input  strb_t data_strb,
    output word_t data_rdata,
    output logic  busy,

    // line-wide memory bus
    output logic  mem_rd_req,
    output addr_t mem_rd_addr,
    input  logic  mem_rd_rdy,
    input  logic  mem_ret_valid,
    input  line_t mem_ret_data,
    output logic  mem_wr_req,
    output addr_t mem_wr_addr,
    output line_t mem_wr_data,
    input  logic  mem_wr_rdy,
    input  logic  mem_wr_valid
);

    index_t    plru_index;
    logic      plru_update;
    way_mask_t plru_hit_way;
    logic      victim;

    dcache_array_if arr_if ();

    dcache_arrays u_arrays (
        .clk   (clk),
        .reset (reset),
        .arr   (arr_if.arrays)
    );

    dcache_plru u_plru (
        .clk     (clk),
        .reset   (reset),
        .index   (plru_index),
        .update  (plru_update),
        .hit_way (plru_hit_way),
        .victim  (victim)
    );

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .data_valid    (data_valid),
        .data_op       (data_op),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .data_strb     (data_strb),
        .data_rdata    (data_rdata),
        .busy          (busy),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data),
        .mem_wr_req    (mem_wr_req),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_valid  (mem_wr_valid),
        .arr           (arr_if.ctrl),
        .plru_index    (plru_index),
        .plru_update   (plru_update),
        .plru_hit_way  (plru_hit_way),
        .victim        (victim)
    );

endmodule

// File: tests/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker import dcache_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  data_valid,
    input logic  data_op,
    input addr_t data_addr,
    input word_t data_wdata,
    input strb_t data_strb,
    input word_t data_rdata,
    input logic  busy,
    input logic  mem_rd_req,
    input addr_t mem_rd_addr,
    input logic  mem_wr_req,
    input addr_t mem_wr_addr,
    input line_t mem_wr_data
);

    word_t ref_mem [addr_t];  // keyed by word address
    int    check_count = 0;
    int    error_count = 0;
    int    rd_req_count = 0;
    int    wr_req_count = 0;
    addr_t last_wr_addr = '0;

    logic  busy_s;
    word_t rdata_s;
    logic  rd_req_d = 1'b0;
    logic  wr_req_d = 1'b0;
    logic  pending;
    logic  pend_op;
    addr_t pend_addr;
    word_t pend_wdata;
    strb_t pend_strb;

    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ ~a ^ 32'h3c96_a55a;
    endfunction

    function automatic word_t ref_word(addr_t a);
        addr_t wa;
        wa = {a[ADDR_WIDTH-1:2], 2'b00};
        return ref_mem.exists(wa) ? ref_mem[wa] : fill_word(wa);
    endfunction

    // expected word after a store
    function automatic word_t merge_word(word_t old, word_t wdata, strb_t strb);
        word_t w;
        w = old;
        for (int b = 0; b < WORD_WIDTH/8; b++) begin
            if (strb[b])
                w[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return w;
    endfunction

    task automatic compare(string name, line_t expected, line_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // outputs settle after the rising edge, so take them here
    always @(negedge clk) begin
        busy_s  = busy;
        rdata_s = data_rdata;
        if (mem_rd_req && !rd_req_d) begin
            rd_req_count++;
            compare("mem_rd_addr", {pend_addr[ADDR_WIDTH-1:OFFSET_WIDTH], 4'h0}, mem_rd_addr);
        end
        if (mem_wr_req && !wr_req_d) begin
            wr_req_count++;
            last_wr_addr = mem_wr_addr;
            for (int k = 0; k < WORDS_PER_LINE; k++)
                compare("mem_wr_data", ref_word(addr_t'(mem_wr_addr + 4*k)),
                        mem_wr_data[k*WORD_WIDTH +: WORD_WIDTH]);
        end
        rd_req_d = mem_rd_req;
        wr_req_d = mem_wr_req;
    end

    always @(posedge clk) begin
        if (reset) begin
            pending = 1'b0;
        end else begin
            if (pending && !busy_s) begin
                if (pend_op)
                    ref_mem[{pend_addr[ADDR_WIDTH-1:2], 2'b00}] =
                        merge_word(ref_word(pend_addr), pend_wdata, pend_strb);
                else
                    compare("data_rdata", ref_word(pend_addr), rdata_s);
                pending = 1'b0;
            end
            if (data_valid && !busy_s) begin  // accept cycle
                pend_op    = data_op;
                pend_addr  = data_addr;
                pend_wdata = data_wdata;
                pend_strb  = data_strb;
                pending    = 1'b1;
            end
        end
    end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    localparam int TIMEOUT = 100;  // cycles per wait

    logic  clk;
    logic  reset;
    logic  data_valid;
    logic  data_op;
    addr_t data_addr;
    word_t data_wdata;
    strb_t data_strb;
    word_t data_rdata;
    logic  busy;
    logic  mem_rd_req;
    addr_t mem_rd_addr;
    logic  mem_rd_rdy;
    logic  mem_ret_valid;
    line_t mem_ret_data;
    logic  mem_wr_req;
    addr_t mem_wr_addr;
    line_t mem_wr_data;
    logic  mem_wr_rdy;
    logic  mem_wr_valid;

    integer seed;
    integer delay_seed;
    int     tb_errors = 0;
    int     tb_checks = 0;
    int     errs_at_start;
    string  test_name;

    // memory model state
    line_t  mem_lines [addr_t];
    int     rd_phase;
    int     rd_wait;
    addr_t  rd_line_addr;
    int     wr_phase;
    int     wr_wait;
    addr_t  wr_line_addr;
    line_t  wr_line;

    dcache_top UUT (
        .clk           (clk),
        .reset         (reset),
        .data_valid    (data_valid),
        .data_op       (data_op),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .data_strb     (data_strb),
        .data_rdata    (data_rdata),
        .busy          (busy),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data),
        .mem_wr_req    (mem_wr_req),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_valid  (mem_wr_valid)
    );

    dcache_checker chk (
        .clk         (clk),
        .reset       (reset),
        .data_valid  (data_valid),
        .data_op     (data_op),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_strb   (data_strb),
        .data_rdata  (data_rdata),
        .busy        (busy),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_addr (mem_rd_addr),
        .mem_wr_req  (mem_wr_req),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ ~a ^ 32'h3c96_a55a;
    endfunction

    function automatic line_t line_at(addr_t line_addr);
        line_t l;
        if (mem_lines.exists(line_addr))
            return mem_lines[line_addr];
        for (int k = 0; k < WORDS_PER_LINE; k++)
            l[k*WORD_WIDTH +: WORD_WIDTH] = fill_word(addr_t'(line_addr + 4*k));
        return l;
    endfunction

    function automatic int rand_delay();
        return 1 + ({$random(delay_seed)} % 4);
    endfunction

    function automatic addr_t make_addr(tag_t tag, index_t index, int word);
        return {tag, index, word[1:0], 2'b00};
    endfunction

    // bus responder with 1 to 4 cycles per pulse
    always @(negedge clk) begin
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_wr_rdy    = 1'b0;
        mem_wr_valid  = 1'b0;
        if (reset) begin
            rd_phase = 0;
            wr_phase = 0;
        end else begin
            case (rd_phase)
                0: if (mem_rd_req) begin
                    rd_line_addr = mem_rd_addr;
                    rd_wait      = rand_delay();
                    rd_phase     = 1;
                end
                1: begin
                    rd_wait--;
                    if (rd_wait == 0) begin
                        mem_rd_rdy = 1'b1;
                        rd_wait    = rand_delay();
                        rd_phase   = 2;
                    end
                end
                default: begin
                    rd_wait--;
                    if (rd_wait == 0) begin
                        mem_ret_valid = 1'b1;
                        mem_ret_data  = line_at(rd_line_addr);
                        rd_phase      = 0;
                    end
                end
            endcase
            case (wr_phase)
                0: if (mem_wr_req) begin
                    wr_line_addr = mem_wr_addr;
                    wr_line      = mem_wr_data;
                    wr_wait      = rand_delay();
                    wr_phase     = 1;
                end
                1: begin
                    wr_wait--;
                    if (wr_wait == 0) begin
                        mem_wr_rdy = 1'b1;
                        wr_wait    = rand_delay();
                        wr_phase   = 2;
                    end
                end
                default: begin
                    wr_wait--;
                    if (wr_wait == 0) begin
                        mem_wr_valid            = 1'b1;
                        mem_lines[wr_line_addr] = wr_line;
                        wr_phase                = 0;
                    end
                end
            endcase
        end
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (busy !== 1'b0) begin
            if (n == TIMEOUT)
                abort_run("timeout: cache stayed busy");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic issue(logic op, addr_t addr, word_t wdata, strb_t strb);
        wait_ready();
        data_valid = 1'b1;
        data_op    = op;
        data_addr  = addr;
        data_wdata = wdata;
        data_strb  = strb;
        @(negedge clk);  // accepted on this edge
        data_valid = 1'b0;
    endtask

    task automatic load(addr_t addr);
        issue(1'b0, addr, '0, '0);
    endtask

    task automatic store(addr_t addr, word_t wdata, strb_t strb);
        issue(1'b1, addr, wdata, strb);
    endtask

    task automatic drain();
        wait_ready();
        @(negedge clk);
    endtask

    task automatic expect_value(string name, logic [31:0] expected, logic [31:0] actual);
        tb_checks++;
        if (actual !== expected) begin
            tb_errors++;
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic start_test(string name);
        test_name     = name;
        errs_at_start = tb_errors + chk.error_count;
    endtask

    task automatic end_test();
        drain();
        $display("test %s %s", test_name,
                 (tb_errors + chk.error_count == errs_at_start) ? "ok" : "failed");
    endtask

    initial begin
        int rd0;
        int wr0;
        int total;
        tag_t   r_tag;
        index_t r_index;
        int     r_word;

        seed          = 32'h2f75_4146;
        delay_seed    = seed + 1;
        reset         = 1'b1;
        data_valid    = 1'b0;
        data_op       = 1'b0;
        data_addr     = '0;
        data_wdata    = '0;
        data_strb     = '0;
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        mem_wr_rdy    = 1'b0;
        mem_wr_valid  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_test("reset_first_load");
        expect_value("busy", 0, busy);
        expect_value("mem_rd_req", 0, mem_rd_req);
        expect_value("mem_wr_req", 0, mem_wr_req);
        rd0 = chk.rd_req_count;
        load(make_addr(20'h12345, 8'h10, 1));
        drain();
        expect_value("refill requests", rd0 + 1, chk.rd_req_count);
        end_test();

        start_test("load_hit");
        rd0 = chk.rd_req_count;
        wr0 = chk.wr_req_count;
        load(make_addr(20'h12345, 8'h10, 3));
        expect_value("busy", 0, busy);
        load(make_addr(20'h12345, 8'h10, 0));  // back to back
        expect_value("busy", 0, busy);
        load(make_addr(20'h12345, 8'h10, 2));
        expect_value("busy", 0, busy);
        drain();
        expect_value("refill requests", rd0, chk.rd_req_count);
        expect_value("writeback requests", wr0, chk.wr_req_count);
        end_test();

        start_test("store_merge");
        store(make_addr(20'h12345, 8'h10, 1), $random(seed), 4'b0101);
        load(make_addr(20'h12345, 8'h10, 1));
        store(make_addr(20'h12345, 8'h10, 2), $random(seed), 4'b1010);
        load(make_addr(20'h12345, 8'h10, 2));
        end_test();

        // A, B, A, C in set 0x20
        start_test("plru_eviction");
        rd0 = chk.rd_req_count;
        wr0 = chk.wr_req_count;
        load(make_addr(20'h00a01, 8'h20, 0));
        load(make_addr(20'h00b02, 8'h20, 1));
        load(make_addr(20'h00a01, 8'h20, 2));
        load(make_addr(20'h00c03, 8'h20, 3));
        drain();
        expect_value("refill requests", rd0 + 3, chk.rd_req_count);
        load(make_addr(20'h00a01, 8'h20, 1));  // still cached
        drain();
        expect_value("refill requests", rd0 + 3, chk.rd_req_count);
        load(make_addr(20'h00b02, 8'h20, 0));
        drain();
        expect_value("refill requests", rd0 + 4, chk.rd_req_count);
        expect_value("writeback requests", wr0, chk.wr_req_count);
        end_test();

        start_test("dirty_writeback");
        wr0 = chk.wr_req_count;
        store(make_addr(20'h00d04, 8'h30, 0), $random(seed), 4'hf);
        store(make_addr(20'h00d04, 8'h30, 3), $random(seed), 4'b0011);
        load(make_addr(20'h00e05, 8'h30, 0));
        load(make_addr(20'h00f06, 8'h30, 0));  // evicts the stored line
        drain();
        expect_value("writeback requests", wr0 + 1, chk.wr_req_count);
        expect_value("mem_wr_addr", make_addr(20'h00d04, 8'h30, 0), chk.last_wr_addr);
        load(make_addr(20'h00d04, 8'h30, 3));
        load(make_addr(20'h00d04, 8'h30, 0));
        end_test();

        start_test("random_mix");
        for (int i = 0; i < 300; i++) begin
            r_tag   = tag_t'(20'h00200 + ({$random(seed)} % 4));
            r_index = index_t'(8'h40 + ({$random(seed)} % 2));
            r_word  = {$random(seed)} % 4;
            if ($random(seed) & 1)
                store(make_addr(r_tag, r_index, r_word), $random(seed), strb_t'($random(seed)));
            else
                load(make_addr(r_tag, r_index, r_word));
        end
        end_test();

        total = tb_errors + chk.error_count;
        $display("checks: %0d, errors: %0d", tb_checks + chk.check_count, total);
        if (total == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: build.f
source/dcache_pkg.sv
source/dcache_array_if.sv
source/dcache_arrays.sv
source/dcache_plru.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tests/dcache_checker.sv
tests/tb_dcache.sv
